// File: hdl/dot11_sig_pkg.sv
/*
 * 802.11 SIGNAL word formats
 * Legacy and HT views of a header word and their data bits per symbol tables
 */
package dot11_sig_pkg;

    typedef logic [63:0] word_t;
    typedef logic [8:0]  dbps_t;
    typedef logic [14:0] psdu_bits_t;

    // Legacy view of header word 0
    typedef struct packed {
        logic [38:0] pad_hi;
        logic        ht_mark;
        logic [6:0]  pad_mid;
        logic [11:0] length;
        logic        reserved;
        logic [3:0]  rate;
    } l_sig_t;

    // HT view of header word 1
    typedef struct packed {
        logic [43:0] pad_hi;
        logic [11:0] length;
        logic [4:0]  pad_lo;
        logic [2:0]  mcs;
    } ht_sig_t;

    typedef union packed {
        l_sig_t  l_sig;
        ht_sig_t ht_sig;
    } sig_word_u;

    localparam logic [3:0] L_RATE_6M = 4'b1011;

    // Index is {~rate[1:0], rate[2]}, so 6 Mbps lands on entry 0
    localparam dbps_t L_DBPS_TABLE [8] = '{
        9'd24, 9'd36, 9'd48, 9'd72, 9'd96, 9'd144, 9'd192, 9'd216
    };

    // Indexed directly by MCS
    localparam dbps_t HT_DBPS_TABLE [8] = '{
        9'd26, 9'd52, 9'd78, 9'd104, 9'd156, 9'd208, 9'd234, 9'd260
    };

endpackage

// File: hdl/tx_coding_pkg.sv
/*
 * DATA field coding constants
 * Field lengths, scrambler taps, convolutional code generators, FCS polynomial
 */
package tx_coding_pkg;

    localparam int SERVICE_BITS = 16;
    localparam int TAIL_BITS    = 6;
    localparam int FCS_BITS     = 32;

    // x^7 + x^4 + 1 scrambler
    localparam int SCRAM_W      = 7;
    localparam int SCRAM_TAP_HI = 6;
    localparam int SCRAM_TAP_LO = 3;

    // K=7 rate-1/2 code, generator MSB taps the current input
    localparam int             ENC_K  = 7;
    localparam logic [ENC_K-1:0] ENC_G0 = 7'o133;
    localparam logic [ENC_K-1:0] ENC_G1 = 7'o171;

    localparam logic [31:0] CRC_POLY_REFL = 32'hEDB88320;

    typedef logic [SCRAM_W-1:0] scram_state_t;
    typedef logic [1:0]         coded_pair_t;

endpackage

// File: hdl/tx_if.sv
/*
 * Bit stream and header config interfaces
 * Valid/ready serial bit link and the serializer to decoder config link
 */
`timescale 1ns/1ps

// One bit per valid/ready handshake
interface bit_stream_if;
    logic valid;
    logic ready;
    logic data_bit;
    logic tail;
    logic last;

    modport source (
        output valid,
        output data_bit,
        output tail,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  data_bit,
        input  tail,
        input  last,
        output ready
    );
endinterface

interface tx_cfg_if;
    dot11_sig_pkg::word_t      hdr_word;
    logic                      load_l;
    logic                      load_ht;
    logic                      is_ht;
    dot11_sig_pkg::dbps_t      n_dbps;
    dot11_sig_pkg::psdu_bits_t psdu_bits;

    modport serializer (
        output hdr_word,
        output load_l,
        output load_ht,
        input  is_ht,
        input  n_dbps,
        input  psdu_bits
    );

    modport decoder (
        input  hdr_word,
        input  load_l,
        input  load_ht,
        output is_ht,
        output n_dbps,
        output psdu_bits
    );
endinterface

// File: hdl/sig_decoder.sv
/*
 * SIGNAL decoder
 * Holds data bits per symbol, PSDU length and packet type for the serializer
 */
`timescale 1ns/1ps

module sig_decoder (
    input  logic      clk,
    input  logic      reset_int,
    tx_cfg_if.decoder cfg
);

    dot11_sig_pkg::sig_word_u sig;
    logic [2:0]               l_idx;
    logic                     l_rate_ok;
    logic                     l_ht_req;

    // Same word seen as L-SIG or HT-SIG depending on the load strobe
    assign sig = cfg.hdr_word;

    // Legal legacy codes all have rate[3] set
    assign l_idx     = {~sig.l_sig.rate[1:0], sig.l_sig.rate[2]};
    assign l_rate_ok = sig.l_sig.rate[3];

    // HT follows only a 6 Mbps L-SIG with the marker bit
    assign l_ht_req  = (sig.l_sig.rate == dot11_sig_pkg::L_RATE_6M) && sig.l_sig.ht_mark;

    ////////////////////////////////////////////////////////////
    // Packet parameter registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_int) begin
            cfg.is_ht     <= 1'b0;
            cfg.n_dbps    <= '0;
            cfg.psdu_bits <= '0;
        end else if (cfg.load_l) begin
            if (l_rate_ok) begin
                cfg.n_dbps <= dot11_sig_pkg::L_DBPS_TABLE[l_idx];
            end else begin
                // Unknown code falls back to 6 Mbps
                cfg.n_dbps <= dot11_sig_pkg::L_DBPS_TABLE[0];
            end
            cfg.psdu_bits <= {sig.l_sig.length, 3'b000};
            cfg.is_ht     <= l_ht_req;
        end else if (cfg.load_ht) begin
            // HT-SIG overrides rate and length, type stays HT
            cfg.n_dbps    <= dot11_sig_pkg::HT_DBPS_TABLE[sig.ht_sig.mcs];
            cfg.psdu_bits <= {sig.ht_sig.length, 3'b000};
        end
    end

endmodule

// File: hdl/crc32_fcs.sv
/*
 * Bit-serial CRC-32 for the frame check sequence
 * Reflected form, register bit 0 leaves first, complemented
 */
`timescale 1ns/1ps

module crc32_fcs (
    input  logic clk,
    input  logic reset_int,
    input  logic i_init,
    input  logic i_en,
    input  logic i_bit,
    input  logic i_shift_out,
    output logic o_fcs_bit
);

    logic [31:0] crc;
    logic        fb;

    assign fb        = crc[0] ^ i_bit;
    assign o_fcs_bit = ~crc[0];

    always_ff @(posedge clk) begin
        if (reset_int || i_init) begin
            crc <= '1;
        end else if (i_en) begin
            // One LFSR step per payload bit
            crc <= (crc >> 1) ^ (fb ? tx_coding_pkg::CRC_POLY_REFL : 32'd0);
        end else if (i_shift_out) begin
            crc <= crc >> 1;
        end
    end

endmodule

// File: hdl/data_serializer.sv
/*
 * DATA field serializer
 * Takes header and PSDU words, emits SERVICE, payload, FCS, tail and pad bits
 */
`timescale 1ns/1ps

module data_serializer (
    input  logic                        clk,
    input  logic                        reset_int,
    input  logic                        i_in_valid,
    input  dot11_sig_pkg::word_t        i_in_word,
    input  tx_coding_pkg::scram_state_t i_scram_seed,
    output logic                        o_in_ready,
    tx_cfg_if.serializer                cfg,
    bit_stream_if.source                src,
    output tx_coding_pkg::scram_state_t o_seed
);

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_HT      = 3'd1;
    localparam logic [2:0] ST_SERVICE = 3'd2;
    localparam logic [2:0] ST_PAYLOAD = 3'd3;
    localparam logic [2:0] ST_FCS     = 3'd4;
    localparam logic [2:0] ST_TAIL    = 3'd5;
    localparam logic [2:0] ST_PAD     = 3'd6;

    logic [2:0]                state;
    logic [2:0]                st_eff;
    logic [5:0]                bit_idx;
    logic [14:0]               field_cnt;
    logic [14:0]               field_lim;
    logic [8:0]                sym_cnt;
    dot11_sig_pkg::word_t      word_q;
    logic                      word_full;
    logic                      want_word;
    logic                      in_fire;
    logic                      fire;
    logic                      field_end;
    logic                      sym_end;
    logic                      fcs_bit;
    dot11_sig_pkg::psdu_bits_t pay_last;

    // After word 0 a legacy packet goes straight into SERVICE
    assign st_eff = (state == ST_HT && !cfg.is_ht) ? ST_SERVICE : state;

    always_comb begin
        case (st_eff)
            ST_IDLE:    want_word = 1'b1;
            ST_HT:      want_word = 1'b1;
            ST_PAYLOAD: want_word = !word_full;
            default:    want_word = 1'b0;
        endcase
    end

    // No word is taken while in reset
    assign o_in_ready  = i_in_valid && want_word && !reset_int;
    assign in_fire     = i_in_valid && o_in_ready;
    assign cfg.hdr_word = i_in_word;
    assign cfg.load_l  = in_fire && (st_eff == ST_IDLE);
    assign cfg.load_ht = in_fire && (st_eff == ST_HT);

    ////////////////////////////////////////////////////////////
    // Field and symbol boundaries
    ////////////////////////////////////////////////////////////
    assign pay_last = cfg.psdu_bits - 15'(tx_coding_pkg::FCS_BITS + 1);

    always_comb begin
        case (st_eff)
            ST_SERVICE: field_lim = 15'(tx_coding_pkg::SERVICE_BITS - 1);
            ST_PAYLOAD: field_lim = pay_last;
            ST_FCS:     field_lim = 15'(tx_coding_pkg::FCS_BITS - 1);
            ST_TAIL:    field_lim = 15'(tx_coding_pkg::TAIL_BITS - 1);
            default:    field_lim = '0;
        endcase
    end

    assign field_end = (field_cnt == field_lim);
    assign sym_end   = (sym_cnt == cfg.n_dbps - 9'd1);

    ////////////////////////////////////////////////////////////
    // Bit stream output
    ////////////////////////////////////////////////////////////
    assign src.valid = (st_eff == ST_SERVICE) || (st_eff == ST_FCS) || (st_eff == ST_TAIL) ||
                       (st_eff == ST_PAD) || (st_eff == ST_PAYLOAD && word_full);
    assign src.tail  = (st_eff == ST_TAIL);
    assign src.last  = (st_eff == ST_TAIL && field_end && sym_end) ||
                       (st_eff == ST_PAD && sym_end);
    assign fire      = src.valid && src.ready;

    always_comb begin
        case (st_eff)
            ST_PAYLOAD: src.data_bit = word_q[bit_idx];
            ST_FCS:     src.data_bit = fcs_bit;
            default:    src.data_bit = 1'b0;
        endcase
    end

    crc32_fcs u_fcs (
        .clk         (clk),
        .reset_int   (reset_int),
        .i_init      (cfg.load_l),
        .i_en        (fire && st_eff == ST_PAYLOAD),
        .i_bit       (word_q[bit_idx]),
        .i_shift_out (fire && st_eff == ST_FCS),
        .o_fcs_bit   (fcs_bit)
    );

    // Word buffer and seed capture
    always_ff @(posedge clk) begin
        if (in_fire && st_eff == ST_PAYLOAD) begin
            word_q <= i_in_word;
        end
        if (cfg.load_l) begin
            o_seed <= i_scram_seed;
        end
    end

    ////////////////////////////////////////////////////////////
    // Packet FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_int) begin
            state     <= ST_IDLE;
            bit_idx   <= '0;
            field_cnt <= '0;
            sym_cnt   <= '0;
            word_full <= 1'b0;
        end else begin
            if (in_fire) begin
                if (st_eff == ST_IDLE) begin
                    state     <= ST_HT;
                    bit_idx   <= '0;
                    field_cnt <= '0;
                    sym_cnt   <= '0;
                end else if (st_eff == ST_HT) begin
                    state <= ST_SERVICE;
                end else begin
                    word_full <= 1'b1;
                end
            end
            if (fire) begin
                sym_cnt   <= sym_end ? 9'd0 : sym_cnt + 9'd1;
                field_cnt <= field_end ? 15'd0 : field_cnt + 15'd1;
                case (st_eff)
                    ST_SERVICE: state <= field_end ? ST_PAYLOAD : ST_SERVICE;
                    ST_PAYLOAD: begin
                        bit_idx <= bit_idx + 6'd1;
                        // Word used up, or rest of last word ignored
                        if (bit_idx == 6'd63 || field_end) begin
                            word_full <= 1'b0;
                        end
                        if (field_end) begin
                            state   <= ST_FCS;
                            bit_idx <= '0;
                        end
                    end
                    ST_FCS: begin
                        if (field_end) begin
                            state <= ST_TAIL;
                        end
                    end
                    ST_TAIL: begin
                        if (field_end) begin
                            state <= sym_end ? ST_IDLE : ST_PAD;
                        end
                    end
                    ST_PAD: begin
                        if (sym_end) begin
                            state <= ST_IDLE;
                        end
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

endmodule

// File: hdl/scrambler.sv
/*
 * DATA scrambler
 * Combinational x^7+x^4+1 stage, seeded per packet, tail bits forced to zero
 */
`timescale 1ns/1ps

module scrambler (
    input  logic                        clk,
    input  logic                        reset_int,
    input  tx_coding_pkg::scram_state_t i_seed,
    bit_stream_if.sink                  s_in,
    bit_stream_if.source                s_out
);

    tx_coding_pkg::scram_state_t state_q;
    tx_coding_pkg::scram_state_t cur;
    logic                        fresh;
    logic                        fb;
    logic                        accept;

    // First bit of a packet runs from the seed itself
    assign cur    = fresh ? i_seed : state_q;
    assign fb     = cur[tx_coding_pkg::SCRAM_TAP_HI] ^ cur[tx_coding_pkg::SCRAM_TAP_LO];
    assign accept = s_in.valid && s_in.ready;

    assign s_out.valid    = s_in.valid;
    assign s_out.tail     = s_in.tail;
    assign s_out.last     = s_in.last;
    assign s_out.data_bit = s_in.tail ? 1'b0 : (s_in.data_bit ^ fb);
    assign s_in.ready     = s_out.ready;

    always_ff @(posedge clk) begin
        if (reset_int) begin
            fresh   <= 1'b1;
            state_q <= '0;
        end else if (accept) begin
            fresh <= s_in.last;
            if (s_in.tail) begin
                state_q <= cur;
            end else begin
                state_q <= {cur[tx_coding_pkg::SCRAM_W-2:0], fb};
            end
        end
    end

endmodule

// File: hdl/conv_encoder.sv
/*
 * Rate-1/2 convolutional encoder, K=7
 * G0/G1 parities held in a one-entry output register
 */
`timescale 1ns/1ps

module conv_encoder (
    input  logic                       clk,
    input  logic                       reset_int,
    bit_stream_if.sink                 s_in,
    output logic                       o_valid,
    input  logic                       i_ready,
    output tx_coding_pkg::coded_pair_t o_pair,
    output logic                       o_last
);

    logic [tx_coding_pkg::ENC_K-2:0] sr;
    logic [tx_coding_pkg::ENC_K-1:0] taps;
    logic                            accept;

    // Register empty or being taken this cycle
    assign s_in.ready = !o_valid || i_ready;
    assign accept     = s_in.valid && s_in.ready;

    // Current bit in the MSB, oldest delay in bit 0
    assign taps = {s_in.data_bit, sr};

    always_ff @(posedge clk) begin
        if (reset_int) begin
            o_valid <= 1'b0;
            o_last  <= 1'b0;
            sr      <= '0;
        end else if (accept) begin
            o_valid <= 1'b1;
            o_last  <= s_in.last;
            // Next packet starts from the zero state
            sr      <= s_in.last ? '0 : taps[tx_coding_pkg::ENC_K-1:1];
        end else if (i_ready) begin
            o_valid <= 1'b0;
            o_last  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_pair <= {^(taps & tx_coding_pkg::ENC_G1), ^(taps & tx_coding_pkg::ENC_G0)};
        end
    end

endmodule

// File: hdl/tx_bits_top.sv
/*
 * 802.11 TX bit front end
 * Header decode, DATA serializer, scrambler and convolutional encoder
 */
`timescale 1ns/1ps

module tx_bits_top (
    input  logic                        clk,
    input  logic                        reset_int,
    input  logic                        i_in_valid,
    input  dot11_sig_pkg::word_t        i_in_word,
    input  tx_coding_pkg::scram_state_t i_scram_seed,
    input  logic                        i_ready,
    output logic                        o_in_ready,
    output logic                        o_valid,
    output tx_coding_pkg::coded_pair_t  o_pair,
    output logic                        o_last
);

    tx_coding_pkg::scram_state_t seed;

    bit_stream_if ser2scr ();
    bit_stream_if scr2enc ();
    tx_cfg_if     cfg ();

    sig_decoder u_sig_decoder (
        .clk       (clk),
        .reset_int (reset_int),
        .cfg       (cfg.decoder)
    );

    data_serializer u_serializer (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_in_valid   (i_in_valid),
        .i_in_word    (i_in_word),
        .i_scram_seed (i_scram_seed),
        .o_in_ready   (o_in_ready),
        .cfg          (cfg.serializer),
        .src          (ser2scr.source),
        .o_seed       (seed)
    );

    scrambler u_scrambler (
        .clk       (clk),
        .reset_int (reset_int),
        .i_seed    (seed),
        .s_in      (ser2scr.sink),
        .s_out     (scr2enc.source)
    );

    conv_encoder u_encoder (
        .clk       (clk),
        .reset_int (reset_int),
        .s_in      (scr2enc.sink),
        .o_valid   (o_valid),
        .i_ready   (i_ready),
        .o_pair    (o_pair),
        .o_last    (o_last)
    );

endmodule

// File: bench/tx_bits_assert.sv
/*
 * Handshake assertions for the TX bit front end
 * Output stability under back-pressure, reset state and last flag qualification
 */
`timescale 1ns/1ps

module tx_bits_assert (
    input logic                       clk,
    input logic                       reset_int,
    input logic                       o_valid,
    input logic                       i_ready,
    input logic                       o_last,
    input logic                       o_in_ready,
    input tx_coding_pkg::coded_pair_t o_pair
);

    int unsigned fail_count = 0;

    // A stalled pair must not move
    hold_while_stalled: assert property (@(posedge clk) disable iff (reset_int)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_pair) && $stable(o_last)))
        else begin
            fail_count++;
            $error("output pair changed while stalled");
        end

    quiet_in_reset: assert property (@(posedge clk)
        (reset_int && $past(reset_int)) |-> (!o_valid && !o_in_ready))
        else begin
            fail_count++;
            $error("handshake active during reset");
        end

    last_needs_valid: assert property (@(posedge clk) disable iff (reset_int)
        o_last |-> o_valid)
        else begin
            fail_count++;
            $error("o_last without o_valid");
        end

endmodule

// File: bench/tb_tx_bits.sv
/*
 * Testbench for the TX bit front end
 * LFSR driven packets checked pair by pair against a DATA field model
 */
`timescale 1ns/1ps

module tb_tx_bits;

    localparam logic [3:0] L_CODES [8] = '{
        4'b1011, 4'b1111, 4'b1010, 4'b1110, 4'b1001, 4'b1101, 4'b1000, 4'b1100
    };

    logic                        clk;
    logic                        reset_int;
    logic                        i_in_valid;
    dot11_sig_pkg::word_t        i_in_word;
    tx_coding_pkg::scram_state_t i_scram_seed;
    logic                        i_ready;
    logic                        o_in_ready;
    logic                        o_valid;
    tx_coding_pkg::coded_pair_t  o_pair;
    logic                        o_last;

    logic [31:0]                 lfsr_state = 32'haf04;
    dot11_sig_pkg::word_t        pay_words [$];
    tx_coding_pkg::coded_pair_t  exp_pairs [$];
    int                          errors = 0;
    int                          tests_run = 0;
    int                          tests_failed = 0;
    bit                          timed_out = 1'b0;

    tx_bits_top uut (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_in_valid   (i_in_valid),
        .i_in_word    (i_in_word),
        .i_scram_seed (i_scram_seed),
        .i_ready      (i_ready),
        .o_in_ready   (o_in_ready),
        .o_valid      (o_valid),
        .o_pair       (o_pair),
        .o_last       (o_last)
    );

    bind tx_bits_top tx_bits_assert u_assert (
        .clk        (clk),
        .reset_int  (reset_int),
        .o_valid    (o_valid),
        .i_ready    (i_ready),
        .o_last     (o_last),
        .o_in_ready (o_in_ready),
        .o_pair     (o_pair)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic int legacy_dbps(input logic [3:0] rate);
        case (rate)
            4'b1111: return 36;
            4'b1010: return 48;
            4'b1110: return 72;
            4'b1001: return 96;
            4'b1101: return 144;
            4'b1000: return 192;
            4'b1100: return 216;
            default: return 24;
        endcase
    endfunction

    function automatic int ht_dbps(input logic [2:0] mcs);
        case (mcs)
            3'd0: return 26;
            3'd1: return 52;
            3'd2: return 78;
            3'd3: return 104;
            3'd4: return 156;
            3'd5: return 208;
            3'd6: return 234;
            default: return 260;
        endcase
    endfunction

    task automatic check_pair(input string name, input int idx,
                              input tx_coding_pkg::coded_pair_t exp,
                              input tx_coding_pkg::coded_pair_t act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: pair %0d expected %b, actual %b", name, idx, exp, act);
        end
    endtask

    task automatic check_last(input string name, input int idx, input logic exp,
                              input logic act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: last flag at pair %0d expected %b, actual %b",
                     name, idx, exp, act);
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Reference model of the DATA field
    //////////////////////////////////////////////////////////////
    task automatic build_expected(input int len_bytes, input int ndbps,
                                  input tx_coding_pkg::scram_state_t seed);
        int          pay_bits;
        int          total;
        int          nb;
        logic [31:0] crc;
        logic [6:0]  scr;
        logic [5:0]  hist;
        logic [6:0]  window;
        logic        b;
        logic        fb;
        logic        tail;
        pay_bits = 8 * len_bytes - 32;
        total    = 16 + 8 * len_bytes + 6;
        nb       = ((total + ndbps - 1) / ndbps) * ndbps;
        crc      = '1;
        scr      = seed;
        hist     = '0;
        exp_pairs.delete();
        for (int i = 0; i < nb; i++) begin
            b    = 1'b0;
            tail = 1'b0;
            if (i >= 16 && i < 16 + pay_bits) begin
                b   = pay_words[(i - 16) / 64][(i - 16) % 64];
                fb  = crc[0] ^ b;
                crc = (crc >> 1) ^ (fb ? 32'hedb88320 : 32'h0);
            end else if (i >= 16 + pay_bits && i < 16 + pay_bits + 32) begin
                // Complemented CRC, bit 0 first
                b = ~crc[i - 16 - pay_bits];
            end else if (i >= 16 + pay_bits + 32 && i < total) begin
                tail = 1'b1;
            end
            if (!tail) begin
                fb  = scr[6] ^ scr[3];
                b   = b ^ fb;
                scr = {scr[5:0], fb};
            end
            window = {b, hist};
            exp_pairs.push_back({^(window & 7'b1111001), ^(window & 7'b1011011)});
            hist = window[6:1];
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Packet driver and output monitor
    //////////////////////////////////////////////////////////////
    task automatic run_packet(input string name, input dot11_sig_pkg::word_t hdr0,
                              input bit has_ht, input dot11_sig_pkg::word_t hdr1,
                              input tx_coding_pkg::scram_state_t seed,
                              input bit gaps, input bit bp, input int len_bytes);
        dot11_sig_pkg::word_t in_words [$];
        int                   w;
        int                   p;
        int                   cycles;
        int                   limit;
        int                   err_before;
        logic                 in_taken;
        in_words.push_back(hdr0);
        if (has_ht) begin
            in_words.push_back(hdr1);
        end
        foreach (pay_words[i]) begin
            in_words.push_back(pay_words[i]);
        end
        w          = 0;
        p          = 0;
        cycles     = 0;
        limit      = 16 * (exp_pairs.size() + in_words.size()) + 500;
        err_before = errors;
        while (p < exp_pairs.size() && !timed_out) begin
            @(negedge clk);
            if (o_valid && i_ready) begin
                check_pair(name, p, exp_pairs[p], o_pair);
                check_last(name, p, (p == exp_pairs.size() - 1), o_last);
                p++;
            end
            in_taken = i_in_valid && o_in_ready;
            cycles++;
            if (cycles > limit) begin
                timed_out = 1'b1;
                $display("Timeout: %s stalled after %0d of %0d pairs",
                         name, p, exp_pairs.size());
            end
            @(posedge clk);
            if (in_taken) begin
                w++;
            end
            // Hold a word until it is taken
            if (in_taken || !i_in_valid) begin
                if (w < in_words.size() && (!gaps || rand_bits(1) != 0)) begin
                    i_in_valid   <= 1'b1;
                    i_in_word    <= in_words[w];
                    i_scram_seed <= seed;
                end else begin
                    i_in_valid <= 1'b0;
                end
            end
            i_ready <= !bp || (rand_bits(1) != 0);
        end
        if (!timed_out && w != in_words.size()) begin
            errors++;
            $display("%s: only %0d of %0d input words were taken", name, w, in_words.size());
        end
        i_ready <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (o_valid) begin
                errors++;
                $display("%s: extra output pair after the last one", name);
            end
        end
        tests_run++;
        if (errors == err_before && !timed_out) begin
            $display("Test %s len=%0d pairs=%0d: ok", name, len_bytes, exp_pairs.size());
        end else begin
            tests_failed++;
            $display("Test %s len=%0d pairs=%0d: failed", name, len_bytes, exp_pairs.size());
        end
    endtask

    task automatic run_random_packet(input bit ht, input logic [3:0] code,
                                     input bit gaps, input bit bp);
        int                          len;
        int                          ndbps;
        int                          nw;
        dot11_sig_pkg::word_t        hdr0;
        dot11_sig_pkg::word_t        hdr1;
        tx_coding_pkg::scram_state_t seed;
        string                       name;
        len  = 5 + int'(rand_bits(7));
        hdr0 = rand_bits(64);
        hdr1 = rand_bits(64);
        seed = 7'(rand_bits(7));
        if (seed == '0) begin
            seed = 7'h5a;
        end
        if (ht) begin
            hdr0[3:0]  = 4'b1011;
            hdr0[24]   = 1'b1;
            hdr1[2:0]  = code[2:0];
            hdr1[19:8] = len[11:0];
            ndbps      = ht_dbps(code[2:0]);
            name       = $sformatf("ht_mcs%0d", code[2:0]);
        end else begin
            hdr0[3:0]  = code;
            hdr0[16:5] = len[11:0];
            // Marker only matters at 6 Mbps
            if (code == 4'b1011) begin
                hdr0[24] = 1'b0;
            end
            ndbps = legacy_dbps(code);
            name  = $sformatf("legacy_%4b", code);
        end
        if (gaps) begin
            name = {name, "_gaps"};
        end
        if (bp) begin
            name = {name, "_bp"};
        end
        pay_words.delete();
        nw = (8 * len - 32 + 63) / 64;
        for (int i = 0; i < nw; i++) begin
            pay_words.push_back(rand_bits(64));
        end
        build_expected(len, ndbps, seed);
        run_packet(name, hdr0, ht, hdr1, seed, gaps, bp, len);
    endtask

    //////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////
    initial begin
        reset_int    = 1'b1;
        i_in_valid   = 1'b1;
        i_in_word    = '1;
        i_scram_seed = 7'h01;
        i_ready      = 1'b0;
        // A word offered during reset must not be taken
        repeat (12) @(posedge clk);
        i_in_valid <= 1'b0;
        repeat (4) @(posedge clk);
        reset_int <= 1'b0;
        @(posedge clk);

        // Outputs quiet before any stimulus
        @(negedge clk);
        tests_run++;
        if (o_valid !== 1'b0 || o_in_ready !== 1'b0) begin
            errors++;
            tests_failed++;
            $display("o_valid or o_in_ready is not low after reset");
            $display("Test reset_state: failed");
        end else begin
            $display("Test reset_state: ok");
        end
        @(posedge clk);
        i_ready <= 1'b1;

        for (int i = 0; i < 8 && !timed_out; i++) begin
            run_random_packet(1'b0, L_CODES[i], 1'b0, 1'b0);
        end
        for (int i = 0; i < 8 && !timed_out; i++) begin
            run_random_packet(1'b1, 4'(i), 1'b0, 1'b0);
        end
        for (int i = 0; i < 8 && !timed_out; i++) begin
            run_random_packet(i[0], i[0] ? 4'(i) : L_CODES[i], 1'b0, 1'b1);
        end
        for (int i = 0; i < 8 && !timed_out; i++) begin
            run_random_packet(i[0], i[0] ? 4'(i) : L_CODES[i], 1'b1, 1'b0);
        end
        for (int i = 0; i < 8 && !timed_out; i++) begin
            run_random_packet(!i[0], !i[0] ? 4'(i) : L_CODES[i], 1'b1, 1'b1);
        end

        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, uut.u_assert.fail_count);
        if (errors == 0 && !timed_out && uut.u_assert.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
hdl/dot11_sig_pkg.sv
hdl/tx_coding_pkg.sv
hdl/tx_if.sv
hdl/sig_decoder.sv
hdl/crc32_fcs.sv
hdl/data_serializer.sv
hdl/scrambler.sv
hdl/conv_encoder.sv
hdl/tx_bits_top.sv
bench/tx_bits_assert.sv
bench/tb_tx_bits.sv

// File: Bender.yml
package:
  name: tx_bits

sources:
  - files:
      - hdl/dot11_sig_pkg.sv
      - hdl/tx_coding_pkg.sv
      - hdl/tx_if.sv
      - hdl/sig_decoder.sv
      - hdl/crc32_fcs.sv
      - hdl/data_serializer.sv
      - hdl/scrambler.sv
      - hdl/conv_encoder.sv
      - hdl/tx_bits_top.sv
  - target: test
    files:
      - bench/tx_bits_assert.sv
      - bench/tb_tx_bits.sv
